// File: common/bus_defines.svh
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// bus widths
`define BUS_AW      32
`define BUS_DW      64

// on-chip ram, byte base and size in 32-bit words
`define RAM_BASE    32'h0000_1000
`define RAM_WORDS   1024

// sdram window, 8 MB starting at 16 MB
`define SDRAM_MIN   32'h0100_0000
`define SDRAM_MAX   32'h0180_0000

// external sdram port
// beat address covers the window in 16-bit units
`define SDRAM_AW    22
`define BEAT_W      16

`endif

// File: common/bus_pkg.sv
`default_nettype none

`include "bus_defines.svh"

package bus_pkg;

    // access size code from the core
    // stores reuse codes 0..3 as sb sh sw sd
    typedef enum logic [2:0] {
        ls_lb  = 3'd0,
        ls_lh  = 3'd1,
        ls_lw  = 3'd2,
        ls_ld  = 3'd3,
        ls_lbu = 3'd4,
        ls_lhu = 3'd5,
        ls_lwu = 3'd6
    } ls_type_e;

    // one 64-bit bus word
    // dw view for ram and extension, beat view for the sdram sequencer
    typedef union packed {
        logic [`BUS_DW-1:0]                    dw;
        logic [`BUS_DW/`BEAT_W-1:0][`BEAT_W-1:0] beat;
    } bus_data_u;

    // request from the core side
    typedef struct packed {
        logic [`BUS_AW-1:0] addr;
        ls_type_e           ls_type;
        bus_data_u          wdata;
        logic               read;
        logic               write;
    } bus_req_t;

    // avalon-style sdram controller port
    typedef struct packed {
        logic [`SDRAM_AW-1:0] addr;
        logic [`BEAT_W-1:0]   wrdata;
        logic [1:0]           byte_en;
        logic                 read;
        logic                 write;
    } sdram_req_t;

    // load result of one part, item already at bit 0
    typedef struct packed {
        logic      valid;
        bus_data_u raw;
    } part_rsp_t;

endpackage

`default_nettype wire

// File: hdl/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align import bus_pkg::*; (
    input  wire logic      CLOCK_50,
    input  wire logic      KEY0,
    input  wire part_rsp_t ram_rsp,
    input  wire part_rsp_t sdram_rsp,
    input  wire part_rsp_t local_rsp,
    input  wire ls_type_e  ls_type,
    output bus_data_u      read_data,
    output logic           load_done
);

    bus_data_u sel;
    bus_data_u ext;

    // at most one source answers per access
    always_comb begin
        if (ram_rsp.valid) begin
            sel = ram_rsp.raw;
        end else if (sdram_rsp.valid) begin
            sel = sdram_rsp.raw;
        end else begin
            sel = local_rsp.raw;
        end
    end

    // cut to size, sign fill for signed loads
    always_comb begin
        case (ls_type)
            ls_lb:   ext.dw = {{56{sel.dw[7]}}, sel.dw[7:0]};
            ls_lh:   ext.dw = {{48{sel.dw[15]}}, sel.dw[15:0]};
            ls_lw:   ext.dw = {{32{sel.dw[31]}}, sel.dw[31:0]};
            ls_lbu:  ext.dw = {56'b0, sel.dw[7:0]};
            ls_lhu:  ext.dw = {48'b0, sel.dw[15:0]};
            ls_lwu:  ext.dw = {32'b0, sel.dw[31:0]};
            // ld passes the full doubleword
            default: ext.dw = sel.dw;
        endcase
    end

    // done pulse lines up with the data register load
    assign load_done = ram_rsp.valid || sdram_rsp.valid || local_rsp.valid;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_data <= '0;
        end else if (load_done) begin
            read_data <= ext;
        end
    end

endmodule

`default_nettype wire

// File: onchip_ram/ram_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module ram_port import bus_pkg::*; (
    input  wire logic     CLOCK_50,
    input  wire logic     KEY0,
    input  wire logic     start,
    input  wire bus_req_t req,
    output part_rsp_t     rsp,
    output logic          write_ack
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    logic [`BUS_AW-1:0] offset;
    logic [IDX_W-1:0]   idx;
    logic               is_dword;
    logic               act;
    logic               finish;
    logic               second_q;
    logic [3:0]         lane_en;
    logic [31:0]        lane_data;
    logic [31:0]        rd_word;
    logic               rsp_valid_q;
    bus_data_u          raw_q;

    // 32-bit word array
    logic [31:0] mem [`RAM_WORDS];

    // byte offset into the ram window
    assign offset = req.addr - `RAM_BASE;

    // second half of ld/sd goes to the following word
    assign idx = second_q ? offset[IDX_W+1:2] + 1'b1 : offset[IDX_W+1:2];

    assign is_dword = (req.ls_type == ls_ld);
    // memory touched in the start cycle and in the second half of ld/sd
    assign act      = start || second_q;
    // last cycle of the access
    assign finish   = (start && !is_dword) || second_q;
    assign rd_word  = mem[idx];

    // store lane select
    always_comb begin
        lane_en   = 4'b0000;
        lane_data = req.wdata.dw[31:0];
        case (req.ls_type)
            // sb, byte copied to all lanes, one lane enabled
            ls_lb: begin
                lane_en   = 4'b0001 << offset[1:0];
                lane_data = {4{req.wdata.dw[7:0]}};
            end
            // sh, low or high half
            ls_lh: begin
                lane_en   = offset[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{req.wdata.dw[15:0]}};
            end
            // sw
            ls_lw: lane_en = 4'b1111;
            // sd, low word first then high word
            ls_ld: begin
                lane_en   = 4'b1111;
                lane_data = second_q ? req.wdata.dw[63:32] : req.wdata.dw[31:0];
            end
            default: lane_en = 4'b0000;
        endcase
    end

    // array write and read capture
    always_ff @(posedge CLOCK_50) begin
        if (act && req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) begin
                    mem[idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
        // item shifted down to bit 0, ld is aligned so low word is unshifted
        if (start && req.read) begin
            raw_q.dw <= {32'b0, rd_word >> (8 * offset[1:0])};
        end else if (second_q && req.read) begin
            raw_q.dw[63:32] <= rd_word;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            second_q    <= 1'b0;
            rsp_valid_q <= 1'b0;
            write_ack   <= 1'b0;
        end else begin
            // ld/sd need a second cycle
            second_q    <= start && is_dword;
            rsp_valid_q <= finish && req.read;
            write_ack   <= finish && req.write;
        end
    end

    assign rsp = '{valid: rsp_valid_q, raw: raw_q};

endmodule

`default_nettype wire

// File: sdram_bridge/sdram_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module sdram_bridge import bus_pkg::*; (
    input  wire logic               CLOCK_50,
    input  wire logic               KEY0,
    input  wire logic               start,
    input  wire bus_req_t           req,
    output sdram_req_t              sdram_req,
    input  wire logic               sdram_wait,
    input  wire logic [`BEAT_W-1:0] sdram_rddata,
    output part_rsp_t               rsp,
    output logic                    write_ack
);

    logic [`BUS_AW-1:0]   offset;
    logic [`SDRAM_AW-1:0] base;
    logic                 is_byte;
    logic [1:0]           last;
    logic                 beat_end;
    logic [7:0]           rd_lane;
    logic                 busy_q;
    logic [1:0]           cnt_q;
    logic                 rsp_valid_q;
    bus_data_u            raw_q;

    // byte offset into the window, halved to a beat address
    assign offset = req.addr - `SDRAM_MIN;
    assign base   = offset[`SDRAM_AW:1];

    assign is_byte = (req.ls_type[1:0] == 2'd0);

    // beats per access: b/h one, w two, d four
    always_comb begin
        case (req.ls_type[1:0])
            2'd2:    last = 2'd1;
            2'd3:    last = 2'd3;
            default: last = 2'd0;
        endcase
    end

    // beat done when the controller stops waiting
    assign beat_end = busy_q && !sdram_wait;

    // byte lane picked by address bit 0
    assign rd_lane = req.addr[0] ? sdram_rddata[15:8] : sdram_rddata[7:0];

    // port held for the whole beat
    always_comb begin
        sdram_req.addr = base + {{(`SDRAM_AW-2){1'b0}}, cnt_q};
        if (is_byte) begin
            // byte copied to both lanes, only one enabled
            sdram_req.wrdata  = {2{req.wdata.dw[7:0]}};
            sdram_req.byte_en = req.addr[0] ? 2'b10 : 2'b01;
        end else begin
            sdram_req.wrdata  = req.wdata.beat[cnt_q];
            sdram_req.byte_en = 2'b11;
        end
        sdram_req.read  = busy_q && req.read;
        sdram_req.write = busy_q && req.write;
    end

    // beat sequencer
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy_q      <= 1'b0;
            cnt_q       <= 2'd0;
            rsp_valid_q <= 1'b0;
            write_ack   <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            write_ack   <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= 2'd0;
            end else if (beat_end) begin
                if (cnt_q == last) begin
                    // answer in the cycle after the last beat
                    busy_q      <= 1'b0;
                    rsp_valid_q <= req.read;
                    write_ack   <= req.write;
                end else begin
                    cnt_q <= cnt_q + 2'd1;
                end
            end
        end
    end

    // read assembly, low beat first
    always_ff @(posedge CLOCK_50) begin
        if (start) begin
            raw_q <= '0;
        end else if (beat_end && req.read) begin
            if (is_byte) begin
                raw_q.beat[0] <= {8'h00, rd_lane};
            end else begin
                raw_q.beat[cnt_q] <= sdram_rddata;
            end
        end
    end

    assign rsp = '{valid: rsp_valid_q, raw: raw_q};

endmodule

`default_nettype wire

// File: hdl/mem_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module mem_bus import bus_pkg::*; (
    input  wire logic               CLOCK_50,
    input  wire logic               KEY0,
    input  wire bus_req_t           req,
    output bus_data_u               read_data,
    output logic                    read_done,
    output logic                    write_done,
    output sdram_req_t              sdram_req,
    input  wire logic               sdram_wait,
    input  wire logic [`BEAT_W-1:0] sdram_rddata
);

    bus_req_t  req_q;
    logic      idle;
    logic      accept_rd;
    logic      accept_wr;
    logic      accept;
    logic      hit_ram;
    logic      hit_sdram;
    logic      start_ram_q;
    logic      start_sdram_q;
    logic      start_none_q;
    logic      local_rd_q;
    logic      local_wr_q;
    part_rsp_t ram_rsp;
    part_rsp_t sdram_rsp;
    part_rsp_t local_rsp;
    logic      ram_wack;
    logic      sdram_wack;
    logic      load_done;

    // new request only while nothing is in flight
    assign idle      = read_done && write_done;
    assign accept_rd = req.read && idle;
    // read wins if both strobes come together
    assign accept_wr = req.write && !req.read && idle;
    assign accept    = accept_rd || accept_wr;

    // region decode on the incoming address
    assign hit_ram   = (req.addr >= `RAM_BASE) && (req.addr < `RAM_BASE + 4 * `RAM_WORDS);
    assign hit_sdram = (req.addr >= `SDRAM_MIN) && (req.addr < `SDRAM_MAX);

    // unmapped loads read as zero
    assign local_rsp = '{valid: local_rd_q, raw: '0};

    // captured request, held stable for the parts until the next accept
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            req_q       <= req;
            req_q.write <= accept_wr;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done     <= 1'b1;
            write_done    <= 1'b1;
            start_ram_q   <= 1'b0;
            start_sdram_q <= 1'b0;
            start_none_q  <= 1'b0;
            local_rd_q    <= 1'b0;
            local_wr_q    <= 1'b0;
        end else begin
            // one-cycle start to exactly one part
            start_ram_q   <= accept && hit_ram;
            start_sdram_q <= accept && hit_sdram;
            start_none_q  <= accept && !hit_ram && !hit_sdram;
            // unmapped access finishes one cycle after its start, like a ram access
            local_rd_q    <= start_none_q && req_q.read;
            local_wr_q    <= start_none_q && req_q.write;

            if (accept_rd) begin
                read_done <= 1'b0;
            end else if (load_done) begin
                read_done <= 1'b1;
            end

            if (accept_wr) begin
                write_done <= 1'b0;
            end else if (ram_wack || sdram_wack || local_wr_q) begin
                write_done <= 1'b1;
            end
        end
    end

    ram_port ram_port_inst (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .start     (start_ram_q),
        .req       (req_q),
        .rsp       (ram_rsp),
        .write_ack (ram_wack)
    );

    sdram_bridge sdram_bridge_inst (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .start        (start_sdram_q),
        .req          (req_q),
        .sdram_req    (sdram_req),
        .sdram_wait   (sdram_wait),
        .sdram_rddata (sdram_rddata),
        .rsp          (sdram_rsp),
        .write_ack    (sdram_wack)
    );

    // all read data passes this one register
    load_align load_align_inst (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ram_rsp   (ram_rsp),
        .sdram_rsp (sdram_rsp),
        .local_rsp (local_rsp),
        .ls_type   (req_q.ls_type),
        .read_data (read_data),
        .load_done (load_done)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic CLOCK_50,
    output logic KEY0
);

    // 8 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    // reset held low for four rising edges, released with the stimulus offset
    initial begin
        KEY0 = 1'b0;
        repeat (4) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module sdram_model import bus_pkg::*; (
    input  wire logic               CLOCK_50,
    input  wire logic               KEY0,
    input  wire sdram_req_t         sdram_req,
    output logic                    sdram_wait,
    output logic [`BEAT_W-1:0]      sdram_rddata
);

    localparam int depth = 1 << `SDRAM_AW;

    // one entry per 16-bit beat address
    logic [`BEAT_W-1:0] mem [depth];
    logic [1:0]         waits_q;
    logic               active;

    assign active       = sdram_req.read || sdram_req.write;
    // beat finishes in the first cycle with no wait left
    assign sdram_wait   = active && (waits_q != 2'd0);
    assign sdram_rddata = mem[sdram_req.addr];

    initial begin
        logic [`SDRAM_AW-1:0] a;
        void'($urandom(78));
        // fill from every address bit so stale beats are easy to spot
        for (int i = 0; i < depth; i++) begin
            a      = `SDRAM_AW'(i);
            mem[i] = a[15:0] ^ {a[21:16], a[21:12]};
        end
    end

    // fresh random wait count for the next beat
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            waits_q <= 2'd0;
        end else if (active) begin
            if (waits_q == 2'd0) begin
                waits_q <= 2'($urandom % 4);
            end else begin
                waits_q <= waits_q - 2'd1;
            end
        end
    end

    // lane writes on the finishing cycle only
    always @(posedge CLOCK_50) begin
        if (sdram_req.write && !sdram_wait) begin
            if (sdram_req.byte_en[0]) begin
                mem[sdram_req.addr][7:0] <= sdram_req.wrdata[7:0];
            end
            if (sdram_req.byte_en[1]) begin
                mem[sdram_req.addr][15:8] <= sdram_req.wrdata[15:8];
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_mem_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module tb_mem_bus import bus_pkg::*; ();

    // about 60 accesses at up to about 20 cycles each plus a wide margin
    localparam int max_cycles = 4000;

    logic               CLOCK_50;
    logic               KEY0;
    bus_req_t           req;
    bus_data_u          read_data;
    logic               read_done;
    logic               write_done;
    sdram_req_t         sdram_req;
    logic               sdram_wait;
    logic [`BEAT_W-1:0] sdram_rddata;

    int errors = 0;
    int checks = 0;
    int cycle_count = 0;

    // expected byte image of everything stored so far
    logic [7:0] ref_mem [logic [31:0]];

    tb_clock tb_clock_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    sdram_model sdram_model_inst (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .sdram_req    (sdram_req),
        .sdram_wait   (sdram_wait),
        .sdram_rddata (sdram_rddata)
    );

    mem_bus mem_bus_inst (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .req          (req),
        .read_data    (read_data),
        .read_done    (read_done),
        .write_done   (write_done),
        .sdram_req    (sdram_req),
        .sdram_wait   (sdram_wait),
        .sdram_rddata (sdram_rddata)
    );

    // watchdog
    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_data(input string name, input bus_data_u got, input bus_data_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %h expected %h", $time, name, got.dw, exp.dw);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_beat(input string name, input logic [`BEAT_W-1:0] got,
                              input logic [`BEAT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // little-endian gather with sign fill only for lb lh lw
    function automatic bus_data_u expect_load(input logic [31:0] addr, input ls_type_e ls);
        bus_data_u v;
        int        n;
        logic      fill;
        v.dw = '0;
        n    = 1 << ls[1:0];
        for (int i = 0; i < n; i++) begin
            v.dw[8*i +: 8] = ref_mem[addr + 32'(i)];
        end
        fill = (ls == ls_lb || ls == ls_lh || ls == ls_lw) && v.dw[8*n-1];
        for (int i = n; i < 8; i++) begin
            v.dw[8*i +: 8] = {8{fill}};
        end
        return v;
    endfunction

    task automatic record_store(input logic [31:0] addr, input ls_type_e ls,
                                input logic [63:0] data);
        int n;
        n = 1 << ls[1:0];
        for (int i = 0; i < n; i++) begin
            ref_mem[addr + 32'(i)] = data[8*i +: 8];
        end
    endtask

    // cycles counted from the request edge until both flags are back up
    task automatic wait_idle(output int lat);
        lat = 0;
        while (!(read_done && write_done)) begin
            @(posedge CLOCK_50);
            #1;
            lat++;
        end
    endtask

    task automatic bus_access(input logic [31:0] addr, input ls_type_e ls,
                              input logic [63:0] wdata, input logic is_read,
                              output bus_data_u rdata, output int lat);
        req.addr     = addr;
        req.ls_type  = ls;
        req.wdata.dw = wdata;
        req.read     = is_read;
        req.write    = !is_read;
        @(posedge CLOCK_50);
        #1;
        req.read  = 1'b0;
        req.write = 1'b0;
        // flag drops right after the request edge
        if (is_read) begin
            check_flag("read_done after request", read_done, 1'b0);
        end else begin
            check_flag("write_done after request", write_done, 1'b0);
        end
        wait_idle(lat);
        rdata = read_data;
    endtask

    // negative latency marks a variable delay that is not checked
    task automatic store_op(input logic [31:0] addr, input ls_type_e ls,
                            input logic [63:0] data, input int exp_lat);
        bus_data_u unused;
        int        lat;
        bus_access(addr, ls, data, 1'b0, unused, lat);
        record_store(addr, ls, data);
        if (exp_lat >= 0) begin
            check_latency($sformatf("store latency @%h", addr), lat, exp_lat);
        end
    endtask

    task automatic load_op(input logic [31:0] addr, input ls_type_e ls, input int exp_lat);
        bus_data_u got;
        int        lat;
        bus_access(addr, ls, 64'h0, 1'b1, got, lat);
        check_data($sformatf("read_data %s @%h", ls.name(), addr), got, expect_load(addr, ls));
        if (exp_lat >= 0) begin
            check_latency($sformatf("load latency @%h", addr), lat, exp_lat);
        end
    endtask

    // unmapped load returns zero after two cycles
    task automatic load_zero(input logic [31:0] addr, input ls_type_e ls);
        bus_data_u got;
        int        lat;
        bus_access(addr, ls, 64'h0, 1'b1, got, lat);
        check_data($sformatf("read_data unmapped @%h", addr), got, '0);
        check_latency($sformatf("unmapped load latency @%h", addr), lat, 2);
    endtask

    task automatic unmapped_store(input logic [31:0] addr, input logic [63:0] data);
        bus_data_u unused;
        int        lat;
        bus_access(addr, ls_ld, data, 1'b0, unused, lat);
        check_latency($sformatf("unmapped store latency @%h", addr), lat, 2);
    endtask

    // model array against the byte image with two bytes per beat
    task automatic compare_sdram_beats(input logic [31:0] addr, input int nbytes);
        logic [31:0]          a;
        logic [31:0]          off;
        logic [`SDRAM_AW-1:0] beat;
        for (int k = 0; k < nbytes; k += 2) begin
            a    = addr + 32'(k);
            off  = (a - `SDRAM_MIN) >> 1;
            beat = off[`SDRAM_AW-1:0];
            check_beat($sformatf("sdram mem[%h]", beat), sdram_model_inst.mem[beat],
                       {ref_mem[a + 32'd1], ref_mem[a]});
        end
    endtask

    // second store offered while write_done is low has to be ignored
    task automatic dropped_store(input logic [31:0] addr, input logic [31:0] blocked);
        int lat;
        req.addr     = addr;
        req.ls_type  = ls_ld;
        req.wdata.dw = 64'h1357_9bdf_2468_ace0;
        req.write    = 1'b1;
        @(posedge CLOCK_50);
        #1;
        check_flag("write_done after request", write_done, 1'b0);
        req.addr     = blocked;
        req.ls_type  = ls_lw;
        req.wdata.dw = 64'hdead_beef_dead_beef;
        @(posedge CLOCK_50);
        #1;
        req.write = 1'b0;
        wait_idle(lat);
        record_store(addr, ls_ld, 64'h1357_9bdf_2468_ace0);
    endtask

    task automatic reset_state_test();
        check_flag("read_done", read_done, 1'b1);
        check_flag("write_done", write_done, 1'b1);
        check_data("read_data", read_data, '0);
        check_flag("sdram_req.read", sdram_req.read, 1'b0);
        check_flag("sdram_req.write", sdram_req.write, 1'b0);
    endtask

    task automatic ram_round_trip();
        logic [31:0] a;
        a = `RAM_BASE + 32'h40;
        store_op(a, ls_ld, 64'h8877_6655_f4e3_d2c1, 3);
        load_op(a, ls_ld, 3);
        load_op(a, ls_lw, 2);
        load_op(a, ls_lwu, 2);
        load_op(a + 32'd4, ls_lw, 2);
        load_op(a + 32'd4, ls_lwu, 2);
        load_op(a + 32'd2, ls_lh, 2);
        load_op(a + 32'd2, ls_lhu, 2);
        load_op(a + 32'd4, ls_lh, 2);
        load_op(a + 32'd3, ls_lb, 2);
        load_op(a + 32'd3, ls_lbu, 2);
        load_op(a + 32'd5, ls_lb, 2);
        load_op(a + 32'd7, ls_lbu, 2);
    endtask

    task automatic ram_byte_lanes();
        logic [31:0] a;
        a = `RAM_BASE + 32'h80;
        store_op(a, ls_lw, 64'h0, 2);
        store_op(a, ls_lb, 64'h11, 2);
        store_op(a + 32'd1, ls_lb, 64'h82, 2);
        store_op(a + 32'd2, ls_lb, 64'h33, 2);
        store_op(a + 32'd3, ls_lb, 64'hc4, 2);
        load_op(a, ls_lw, 2);
        // high half replaced and low half kept
        store_op(a + 32'd4, ls_lw, 64'haabb_ccdd, 2);
        store_op(a + 32'd6, ls_lh, 64'h1234, 2);
        load_op(a + 32'd4, ls_lw, 2);
        load_op(a + 32'd4, ls_lhu, 2);
        // single lane in a word that already holds data
        store_op(a + 32'd8, ls_lw, 64'h7766_5544, 2);
        store_op(a + 32'd9, ls_lb, 64'hee, 2);
        load_op(a + 32'd8, ls_lw, 2);
    endtask

    task automatic sdram_round_trip();
        logic [31:0] a;
        a = `SDRAM_MIN + 32'h100;
        store_op(a, ls_ld, 64'h0f1e_2d3c_4b5a_6978, -1);
        store_op(a + 32'd8, ls_lw, 64'h9abc_def0, -1);
        store_op(a + 32'd12, ls_lh, 64'h8421, -1);
        store_op(a + 32'd14, ls_lb, 64'h7e, -1);
        store_op(a + 32'd15, ls_lb, 64'h81, -1);
        compare_sdram_beats(a, 16);
        // even byte store leaves the odd lane alone
        store_op(a + 32'd4, ls_lb, 64'ha5, -1);
        compare_sdram_beats(a + 32'd4, 2);
        load_op(a, ls_ld, -1);
        load_op(a + 32'd4, ls_lw, -1);
        load_op(a + 32'd8, ls_lw, -1);
        load_op(a + 32'd8, ls_lwu, -1);
        load_op(a + 32'd12, ls_lh, -1);
        load_op(a + 32'd12, ls_lhu, -1);
        load_op(a + 32'd2, ls_lh, -1);
        load_op(a + 32'd15, ls_lb, -1);
        load_op(a + 32'd15, ls_lbu, -1);
        load_op(a + 32'd14, ls_lb, -1);
        load_op(a + 32'd1, ls_lbu, -1);
    endtask

    task automatic mixed_regions();
        logic [31:0] holes [3];
        logic [31:0] ra;
        logic [31:0] sa;
        logic [63:0] d;
        // just below ram, just past ram, first byte past the sdram window
        holes = '{32'h0000_0ff8, 32'h0000_2000, `SDRAM_MAX};
        for (int i = 0; i < 3; i++) begin
            ra = `RAM_BASE + 32'h100 + 32'(8 * i);
            sa = `SDRAM_MIN + 32'h2000 + 32'(4 * i);
            d  = 64'hc3d2_e1f0_8796_a5b4 + 64'(i) * 64'h0101_0101_0101_0101;
            store_op(ra, ls_ld, d, 3);
            store_op(sa, ls_lw, ~d, -1);
            unmapped_store(holes[i], d);
            // each unmapped load follows a load with nonzero data
            load_op(ra, ls_ld, 3);
            load_zero(holes[i], ls_ld);
            load_op(sa, ls_lw, -1);
            load_zero(holes[i], ls_lb);
        end
        dropped_store(`SDRAM_MIN + 32'h3000, `RAM_BASE + 32'h84);
        load_op(`RAM_BASE + 32'h84, ls_lw, 2);
        load_op(`SDRAM_MIN + 32'h3000, ls_ld, -1);
    endtask

    initial begin
        req = '0;
        @(posedge KEY0);
        @(posedge CLOCK_50);
        #1;
        reset_state_test();
        ram_round_trip();
        ram_byte_lanes();
        sdram_round_trip();
        mixed_regions();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/bus_pkg.sv
hdl/load_align.sv
onchip_ram/ram_port.sv
sdram_bridge/sdram_bridge.sv
hdl/mem_bus.sv
sim/tb_clock.sv
sim/sdram_model.sv
sim/tb_mem_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it
# exit status is nonzero when the build, the run or the testbench fails

set -u
cd "$(dirname "$0")"

build_log=build.log
sim_log=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f vlog.f --top-module tb_mem_bus -Mdir obj_dir -o tb_mem_bus > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_mem_bus > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# verdict comes from the log
if grep -qF '** FAIL **' "$sim_log"; then
    exit 1
fi
exit 0
